// ==== logic/idPkg.sv ====
`default_nettype none

package idPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int dataWidth   = 16;
    localparam int instrWidth  = 16;
    localparam int regIdxWidth = 4;
    localparam int numRegs     = 2 ** regIdxWidth;

    typedef logic [dataWidth-1:0]   data_t;
    typedef logic [instrWidth-1:0]  instr_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;

    // Special registers
    localparam regIdx_t regSp   = 4'd8;   // Stack pointer
    localparam regIdx_t regT    = 4'd9;   // Condition flag T
    localparam regIdx_t regIh   = 4'd10;  // Interrupt high
    localparam regIdx_t regNone = 4'd15;  // No register, reads as zero

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Major opcode, instr[15:11]
    typedef enum logic [4:0] {
        opNop     = 5'b00001,
        opB       = 5'b00010,
        opBeqz    = 5'b00100,
        opBnez    = 5'b00101,
        opShift   = 5'b00110,
        opAddiu3  = 5'b01000,
        opAddiu   = 5'b01001,
        opCmpi    = 5'b01011,
        opSpGroup = 5'b01100,
        opLi      = 5'b01101,
        opMove    = 5'b01111,
        opLwSp    = 5'b10010,
        opLw      = 5'b10011,
        opSwSp    = 5'b11010,
        opSw      = 5'b11011,
        opRrr     = 5'b11100,
        opRr      = 5'b11101,
        opIh      = 5'b11110
    } opcode_t;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNeg = 4'd4,
        aluNot = 4'd5,
        aluSll = 4'd6,
        aluSra = 4'd8,
        aluCmp = 4'd9,
        aluSlt = 4'd10,
        aluPc  = 4'd11   // Pass the PC through
    } aluOp_t;

    typedef enum logic [1:0] {
        bReg  = 2'd0,
        bImm  = 2'd1,
        bNone = 2'd2
    } srcB_t;

    typedef enum logic [1:0] {
        memRead  = 2'd1,
        memWrite = 2'd2,
        memNone  = 2'd3
    } memOp_t;

    typedef enum logic [2:0] {
        brNone,
        brUncond,
        brJr,
        brEqz,
        brNez
    } branch_t;

endpackage

`default_nettype wire

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
    import idPkg::*;
(
    input  wire instr_t instr,
    output regIdx_t     readReg1,
    output regIdx_t     readReg2,
    output regIdx_t     writeReg,
    output aluOp_t      aluOp,
    output srcB_t       srcB,
    output memOp_t      memOp,
    output branch_t     branch,
    output logic        memToReg,
    output data_t       imm
);

    opcode_t opcode;
    regIdx_t rx;
    regIdx_t ry;
    regIdx_t rz;

    data_t immS11;
    data_t immS8;
    data_t immZ8;
    data_t immS5;
    data_t immS4;
    data_t shiftAmt;

    assign opcode = opcode_t'(instr[15:11]);

    assign rx = {1'b0, instr[10:8]};
    assign ry = {1'b0, instr[7:5]};
    assign rz = {1'b0, instr[4:2]};

    ////////////////////////////////////////////////////////////
    // Immediate forms
    ////////////////////////////////////////////////////////////

    assign immS11 = {{5{instr[10]}}, instr[10:0]};
    assign immS8  = {{8{instr[7]}}, instr[7:0]};
    assign immZ8  = {8'd0, instr[7:0]};
    assign immS5  = {{11{instr[4]}}, instr[4:0]};
    assign immS4  = {{12{instr[3]}}, instr[3:0]};
    assign shiftAmt = (instr[4:2] == 3'd0) ? 16'd8 : {13'd0, instr[4:2]};  // 0 means 8

    always_comb begin
        // Bubble unless an encoding below says otherwise
        readReg1 = regNone;
        readReg2 = regNone;
        writeReg = regNone;
        aluOp    = aluAdd;
        srcB     = bNone;
        memOp    = memNone;
        branch   = brNone;
        memToReg = 1'b1;
        imm      = '0;

        case (opcode)
            opB: begin
                imm    = immS11;
                branch = brUncond;
            end
            opBeqz, opBnez: begin
                readReg1 = rx;
                aluOp    = aluSub;
                imm      = immS8;
                branch   = (opcode == opBeqz) ? brEqz : brNez;
            end
            opShift: begin
                if (instr[1:0] == 2'b00 || instr[1:0] == 2'b11) begin
                    readReg1 = ry;
                    writeReg = rx;
                    aluOp    = instr[0] ? aluSra : aluSll;
                    srcB     = bImm;
                    imm      = shiftAmt;
                end
            end
            opAddiu3: begin
                readReg1 = rx;
                writeReg = ry;
                srcB     = bImm;
                imm      = immS4;
            end
            opAddiu: begin
                readReg1 = rx;
                writeReg = rx;
                srcB     = bImm;
                imm      = immS8;
            end
            opCmpi: begin
                readReg1 = rx;
                writeReg = regT;
                aluOp    = aluCmp;
                imm      = immZ8;
            end
            opSpGroup: begin
                case (instr[10:8])
                    3'b011: begin  // ADDSP
                        readReg1 = regSp;
                        writeReg = regSp;
                        srcB     = bImm;
                        imm      = immS8;
                    end
                    3'b000: begin  // BTEQZ
                        readReg1 = regT;
                        aluOp    = aluSub;
                        imm      = immS8;
                        branch   = brEqz;
                    end
                    3'b100: begin  // MTSP
                        readReg1 = ry;
                        writeReg = regSp;
                    end
                    default: ;
                endcase
            end
            opLi: begin
                writeReg = rx;
                srcB     = bImm;
                imm      = immZ8;
            end
            opMove: begin
                readReg1 = ry;
                writeReg = rx;
                srcB     = bReg;
            end
            opLwSp, opLw: begin
                readReg1 = (opcode == opLwSp) ? regSp : rx;
                writeReg = (opcode == opLwSp) ? rx : ry;
                memOp    = memRead;
                memToReg = 1'b0;
                imm      = (opcode == opLwSp) ? immS8 : immS5;
            end
            opSwSp: begin
                readReg1 = regSp;
                readReg2 = rx;
                memOp    = memWrite;
                imm      = immS8;
            end
            opSw: begin
                readReg1 = rx;
                readReg2 = ry;
                memOp    = memWrite;
                srcB     = bImm;
                imm      = immS5;
            end
            opRrr: begin
                if (instr[0]) begin  // func 01 ADDU, 11 SUBU
                    readReg1 = rx;
                    readReg2 = ry;
                    writeReg = rz;
                    aluOp    = instr[1] ? aluSub : aluAdd;
                end
            end
            opRr: begin
                case (instr[4:0])
                    5'b00000: begin
                        if (instr[7:5] == 3'b000) begin  // JR
                            readReg1 = rx;
                            branch   = brJr;
                        end else if (instr[7:5] == 3'b010) begin  // MFPC
                            writeReg = rx;
                            aluOp    = aluPc;
                        end
                    end
                    5'b00010, 5'b01010: begin  // CMP, SLT
                        readReg1 = rx;
                        readReg2 = ry;
                        writeReg = regT;
                        aluOp    = instr[3] ? aluSlt : aluCmp;
                    end
                    5'b01011, 5'b01111: begin  // NEG, NOT
                        readReg1 = ry;
                        writeReg = rx;
                        aluOp    = instr[2] ? aluNot : aluNeg;
                    end
                    5'b01100, 5'b01101: begin  // AND, OR
                        readReg1 = rx;
                        readReg2 = ry;
                        writeReg = rx;
                        aluOp    = instr[0] ? aluOr : aluAnd;
                    end
                    default: ;
                endcase
            end
            opIh: begin
                if (instr[7:0] == 8'h00) begin  // MFIH
                    readReg1 = regIh;
                    writeReg = rx;
                end else if (instr[7:0] == 8'h01) begin  // MTIH
                    readReg1 = rx;
                    writeReg = regIh;
                end
            end
            default: ;
        endcase

        if (!$isunknown(instr)) begin
            assert (!$isunknown(writeReg))
                else $error("writeReg unknown for instr %h", instr);
        end
    end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile
    import idPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire regIdx_t wbReg,
    input  wire data_t   wbData,
    input  wire regIdx_t readReg1,
    input  wire regIdx_t readReg2,
    output data_t        readData1,
    output data_t        readData2
);

    data_t regs [numRegs];

    // Zero register first, then bypass from write-back
    function automatic data_t readPort(input regIdx_t idx);
        if (idx == regNone) begin
            return '0;
        end else if (idx == wbReg) begin
            return wbData;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbReg != regNone) begin
            regs[wbReg] <= wbData;
        end
    end

    always_comb begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    regNoneZero: assert property (
        @(posedge clk) disable iff (!rst)
        regs[regNone] == '0
    ) else $error("register 15 holds %h", regs[regNone]);

endmodule

`default_nettype wire

// ==== logic/idExLatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module idExLatch
    import idPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    instrValid,
    input  wire logic    memToReg,
    input  wire aluOp_t  aluOp,
    input  wire srcB_t   srcB,
    input  wire memOp_t  memOp,
    input  wire branch_t branch,
    input  wire regIdx_t writeReg,
    input  wire regIdx_t readReg1,
    input  wire regIdx_t readReg2,
    input  wire data_t   readData1,
    input  wire data_t   readData2,
    input  wire data_t   imm,
    output aluOp_t       outAluOp,
    output srcB_t        outSrcB,
    output memOp_t       outMemOp,
    output branch_t      outBranch,
    output logic         outMemToReg,
    output regIdx_t      outWriteReg,
    output regIdx_t      outReadReg1,
    output regIdx_t      outReadReg2,
    output data_t        outData1,
    output data_t        outData2,
    output data_t        outImm,
    output logic         outValid
);

    always_ff @(posedge clk) begin
        outValid <= rst && instrValid;
        if (!rst || !instrValid) begin  // Bubble
            outAluOp    <= aluAdd;
            outSrcB     <= bNone;
            outMemOp    <= memNone;
            outBranch   <= brNone;
            outMemToReg <= 1'b1;
            outWriteReg <= regNone;
            outReadReg1 <= regNone;
            outReadReg2 <= regNone;
            outData1    <= '0;
            outData2    <= '0;
            outImm      <= '0;
        end else begin
            outAluOp    <= aluOp;
            outSrcB     <= srcB;
            outMemOp    <= memOp;
            outBranch   <= branch;
            outMemToReg <= memToReg;
            outWriteReg <= writeReg;
            outReadReg1 <= readReg1;
            outReadReg2 <= readReg2;
            outData1    <= readData1;
            outData2    <= readData2;
            outImm      <= imm;
        end
    end

    // An invalid slot must never write a register or touch memory
    bubbleQuiet: assert property (
        @(posedge clk) disable iff (!rst)
        !outValid |-> (outWriteReg == regNone && outMemOp == memNone)
    ) else $error("bubble carries a side effect");

endmodule

`default_nettype wire

// ==== logic/idStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStage
    import idPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire instr_t  instr,
    input  wire logic    instrValid,
    input  wire regIdx_t wbReg,
    input  wire data_t   wbData,
    output aluOp_t       outAluOp,
    output srcB_t        outSrcB,
    output memOp_t       outMemOp,
    output branch_t      outBranch,
    output logic         outMemToReg,
    output regIdx_t      outWriteReg,
    output regIdx_t      outReadReg1,
    output regIdx_t      outReadReg2,
    output data_t        outData1,
    output data_t        outData2,
    output data_t        outImm,
    output logic         outValid
);

    wire regIdx_t readReg1;
    wire regIdx_t readReg2;
    wire regIdx_t writeReg;
    wire aluOp_t  aluOp;
    wire srcB_t   srcB;
    wire memOp_t  memOp;
    wire branch_t branch;
    wire logic    memToReg;
    wire data_t   imm;
    wire data_t   readData1;
    wire data_t   readData2;

    ////////////////////////////////////////////////////////////
    // Decode, operand fetch, ID/EX register
    ////////////////////////////////////////////////////////////

    instrDecoder decoder_i (
        .instr    (instr),
        .readReg1 (readReg1),
        .readReg2 (readReg2),
        .writeReg (writeReg),
        .aluOp    (aluOp),
        .srcB     (srcB),
        .memOp    (memOp),
        .branch   (branch),
        .memToReg (memToReg),
        .imm      (imm)
    );

    regFile regFile_i (
        .clk       (clk),
        .rst       (rst),
        .wbReg     (wbReg),
        .wbData    (wbData),
        .readReg1  (readReg1),
        .readReg2  (readReg2),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    idExLatch latch_i (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .memToReg    (memToReg),
        .aluOp       (aluOp),
        .srcB        (srcB),
        .memOp       (memOp),
        .branch      (branch),
        .writeReg    (writeReg),
        .readReg1    (readReg1),
        .readReg2    (readReg2),
        .readData1   (readData1),
        .readData2   (readData2),
        .imm         (imm),
        .outAluOp    (outAluOp),
        .outSrcB     (outSrcB),
        .outMemOp    (outMemOp),
        .outBranch   (outBranch),
        .outMemToReg (outMemToReg),
        .outWriteReg (outWriteReg),
        .outReadReg1 (outReadReg1),
        .outReadReg2 (outReadReg2),
        .outData1    (outData1),
        .outData2    (outData2),
        .outImm      (outImm),
        .outValid    (outValid)
    );

endmodule

`default_nettype wire

// ==== sim/idStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStageTb
    import idPkg::*;
();

    localparam int fieldsPerVec = 16;
    localparam int maxVectors   = 64;
    localparam int memWords     = fieldsPerVec * maxVectors;

    logic    clk;
    logic    rst;
    instr_t  instr;
    logic    instrValid;
    regIdx_t wbReg;
    data_t   wbData;

    aluOp_t  outAluOp;
    srcB_t   outSrcB;
    memOp_t  outMemOp;
    branch_t outBranch;
    logic    outMemToReg;
    regIdx_t outWriteReg;
    regIdx_t outReadReg1;
    regIdx_t outReadReg2;
    data_t   outData1;
    data_t   outData2;
    data_t   outImm;
    logic    outValid;

    logic [15:0] vecMem [memWords];
    int          numVectors  = 0;
    int          limit       = 0;
    int          cycles      = 0;
    int          checks      = 0;
    int          mismatches  = 0;
    int          otherErrors = 0;

    idStage dut_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instrValid  (instrValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .outAluOp    (outAluOp),
        .outSrcB     (outSrcB),
        .outMemOp    (outMemOp),
        .outBranch   (outBranch),
        .outMemToReg (outMemToReg),
        .outWriteReg (outWriteReg),
        .outReadReg1 (outReadReg1),
        .outReadReg2 (outReadReg2),
        .outData1    (outData1),
        .outData2    (outData2),
        .outImm      (outImm),
        .outValid    (outValid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic checkAlu(input string name, input aluOp_t exp, input aluOp_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkSrcB(input string name, input srcB_t exp, input srcB_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkMem(input string name, input memOp_t exp, input memOp_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkBranch(input string name, input branch_t exp, input branch_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkReg(input string name, input regIdx_t exp, input regIdx_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkData(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic checkOutputs(
        input string   tag,
        input logic    expValid,
        input aluOp_t  expAlu,
        input srcB_t   expSrcB,
        input memOp_t  expMem,
        input branch_t expBranch,
        input logic    expMemToReg,
        input regIdx_t expWrite,
        input regIdx_t expRead1,
        input regIdx_t expRead2,
        input data_t   expData1,
        input data_t   expData2,
        input data_t   expImm
    );
        checkBit({tag, " outValid"}, expValid, outValid);
        checkAlu({tag, " outAluOp"}, expAlu, outAluOp);
        checkSrcB({tag, " outSrcB"}, expSrcB, outSrcB);
        checkMem({tag, " outMemOp"}, expMem, outMemOp);
        checkBranch({tag, " outBranch"}, expBranch, outBranch);
        checkBit({tag, " outMemToReg"}, expMemToReg, outMemToReg);
        checkReg({tag, " outWriteReg"}, expWrite, outWriteReg);
        checkReg({tag, " outReadReg1"}, expRead1, outReadReg1);
        checkReg({tag, " outReadReg2"}, expRead2, outReadReg2);
        checkData({tag, " outData1"}, expData1, outData1);
        checkData({tag, " outData2"}, expData2, outData2);
        checkData({tag, " outImm"}, expImm, outImm);
    endtask

    ////////////////////////////////////////////////////////////
    // Vector access
    ////////////////////////////////////////////////////////////

    task automatic driveVector(input int idx);
        int base;
        base = idx * fieldsPerVec;
        instr      <= vecMem[base];
        instrValid <= vecMem[base + 1][0];
        wbReg      <= vecMem[base + 2][3:0];
        wbData     <= vecMem[base + 3];
    endtask

    task automatic checkVector(input int idx);
        int    base;
        string tag;
        base = idx * fieldsPerVec;
        tag  = $sformatf("vector %0d", idx);
        checkOutputs(tag,
            vecMem[base + 4][0],
            aluOp_t'(vecMem[base + 5][3:0]),
            srcB_t'(vecMem[base + 6][1:0]),
            memOp_t'(vecMem[base + 7][1:0]),
            branch_t'(vecMem[base + 8][2:0]),
            vecMem[base + 9][0],
            vecMem[base + 10][3:0],
            vecMem[base + 11][3:0],
            vecMem[base + 12][3:0],
            vecMem[base + 13],
            vecMem[base + 14],
            vecMem[base + 15]);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        rst        = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        wbReg      = regNone;
        wbData     = '0;

        // Valid column of unused slots stays at ffff
        for (int i = 0; i < memWords; i++) begin
            vecMem[i] = 16'hffff;
        end
        $readmemh("sim/idTestdata.txt", vecMem);
        while (numVectors < maxVectors
               && vecMem[numVectors * fieldsPerVec + 1] != 16'hffff) begin
            numVectors++;
        end
        limit = numVectors * 2 + 20;
        if (numVectors == 0) begin
            $display("no test vectors could be read from sim/idTestdata.txt");
            otherErrors++;
        end

        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        checkOutputs("after reset", 1'b0, aluAdd, bNone, memNone, brNone, 1'b1,
                     regNone, regNone, regNone, '0, '0, '0);

        for (int i = 0; i < numVectors; i++) begin
            @(posedge clk);
            driveVector(i);
            @(negedge clk);
            if (i > 0) begin
                checkVector(i - 1);  // Latched one edge after driving
            end
        end

        // One idle edge flushes the last vector
        @(posedge clk);
        instr      <= '0;
        instrValid <= 1'b0;
        wbReg      <= regNone;
        wbData     <= '0;
        @(negedge clk);
        if (numVectors > 0) begin
            checkVector(numVectors - 1);
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/idTestdata.txt ====
// instr valid wbReg wbData | expected outValid aluOp srcB memOp branch memToReg
// writeReg readReg1 readReg2 data1 data2 imm, seen one cycle after the line is driven
0000 0 f 0000  0 0 2 3 0 1 f f f 0000 0000 0000
E94C 1 f 0000  1 2 2 3 0 1 1 1 2 0000 0000 0000
// Write-back with no strobe, r15 write dropped
0000 0 1 1234  0 0 2 3 0 1 f f f 0000 0000 0000
0000 0 2 abcd  0 0 2 3 0 1 f f f 0000 0000 0000
0000 0 f ffff  0 0 2 3 0 1 f f f 0000 0000 0000
0000 0 8 0100  0 0 2 3 0 1 f f f 0000 0000 0000
0000 0 9 5a5a  0 0 2 3 0 1 f f f 0000 0000 0000
0000 0 a 00aa  0 0 2 3 0 1 f f f 0000 0000 0000
// Decoder table, back to back
1400 1 3 0333  1 0 2 3 1 1 f f f 0000 0000 fc00
2180 1 f 0000  1 1 2 3 3 1 f 1 f 1234 0000 ff80
2A7F 1 f 0000  1 1 2 3 4 1 f 2 f abcd 0000 007f
3320 1 f 0000  1 6 1 3 0 1 3 1 f 1234 0000 0008
3457 1 f 0000  1 8 1 3 0 1 4 2 f abcd 0000 0005
3455 1 f 0000  1 0 2 3 0 1 f f f 0000 0000 0000
41A8 1 f 0000  1 0 1 3 0 1 5 1 f 1234 0000 fff8
4A85 1 f 0000  1 0 1 3 0 1 2 2 f abcd 0000 ff85
5B85 1 f 0000  1 9 2 3 0 1 9 3 f 0333 0000 0085
63F0 1 f 0000  1 0 1 3 0 1 8 8 f 0100 0000 fff0
6010 1 f 0000  1 1 2 3 3 1 f 9 f 5a5a 0000 0010
6460 1 f 0000  1 0 2 3 0 1 8 3 f 0333 0000 0000
6100 1 f 0000  1 0 2 3 0 1 f f f 0000 0000 0000
6EC3 1 f 0000  1 0 1 3 0 1 6 f f 0000 0000 00c3
7F40 1 f 0000  1 0 0 3 0 1 7 2 f abcd 0000 0000
0000 0 f 0000  0 0 2 3 0 1 f f f 0000 0000 0000
9581 1 f 0000  1 0 2 1 0 0 5 8 f 0100 0000 ff81
9991 1 f 0000  1 0 2 1 0 0 4 1 f 1234 0000 fff1
D212 1 f 0000  1 0 2 2 0 1 f 8 2 0100 abcd 0012
DB2F 1 f 0000  1 0 1 2 0 1 f 3 1 0333 1234 000f
E14D 1 f 0000  1 0 2 3 0 1 3 1 2 1234 abcd 0000
E273 1 f 0000  1 1 2 3 0 1 4 2 3 abcd 0333 0000
E270 1 f 0000  1 0 2 3 0 1 f f f 0000 0000 0000
EB00 1 f 0000  1 0 2 3 2 1 f 3 f 0333 0000 0000
ED40 1 f 0000  1 b 2 3 0 1 5 f f 0000 0000 0000
E942 1 f 0000  1 9 2 3 0 1 9 1 2 1234 abcd 0000
EA6A 1 f 0000  1 a 2 3 0 1 9 2 3 abcd 0333 0000
EC2B 1 f 0000  1 4 2 3 0 1 4 1 f 1234 0000 0000
EE4F 1 f 0000  1 5 2 3 0 1 6 2 f abcd 0000 0000
EB2D 1 f 0000  1 3 2 3 0 1 3 3 1 0333 1234 0000
E81F 1 f 0000  1 0 2 3 0 1 f f f 0000 0000 0000
F700 1 f 0000  1 0 2 3 0 1 7 a f 00aa 0000 0000
F201 1 f 0000  1 0 2 3 0 1 a 2 f abcd 0000 0000
F800 1 f 0000  1 0 2 3 0 1 f f f 0000 0000 0000
0800 1 f 0000  1 0 2 3 0 1 f f f 0000 0000 0000
// Forwarding on each read port, then the stored values
E14D 1 1 5555  1 0 2 3 0 1 3 1 2 5555 abcd 0000
DB4F 1 2 7777  1 0 1 2 0 1 f 3 2 0333 7777 000f
E14D 1 f 0000  1 0 2 3 0 1 3 1 2 5555 7777 0000
0000 0 f 0000  0 0 2 3 0 1 f f f 0000 0000 0000

// ==== sources.f ====
logic/idPkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/idExLatch.sv
logic/idStage.sv
sim/idStageTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = idStageTb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
